// ==== gnn_agg.f ====
+incdir+src
src/gnn_types_pkg.sv
src/gnn_ctrl_pkg.sv
src/rr_arbiter.sv
src/edge_pe.sv
src/replay_counter.sv
src/task_dispatcher.sv
src/graph_memory.sv
src/gnn_top.sv
verification/wb_host.sv
verification/gnn_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    -f gnn_agg.f --top-module gnn_tb -o gnn_sim \
    && ./obj_dir/gnn_sim | tee /dev/stderr | grep -q "^Verification passed$" \
    && exit 0 \
    || exit 1

// ==== verification/gnn_tb.sv ====
`include "gnn_params.svh"

module gnn_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS      = 6;
    localparam int NODES          = `GNN_NUM_NODES;
    localparam int DEG            = `GNN_DEGREE;
    localparam int OFS_W          = `GNN_WB_ADR_W - 2;   // offset bits under the region
    localparam int RUN_LIMIT      = `GNN_MAX_REPLAY * NODES * 40;   // one run, worst case
    localparam int TIMEOUT_CYCLES = NUM_TESTS * RUN_LIMIT;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`GNN_WB_ADR_W-1:0] wb_adr;
    gnn_types_pkg::feat_t     wb_dat_w;
    gnn_types_pkg::feat_t     wb_dat_r;
    logic                     wb_ack;
    logic                     task_complete;

    // reference copy of the graph, feat_m turns into outputs pass by pass
    gnn_types_pkg::feat_t    feat_m [NODES];
    gnn_types_pkg::node_id_t nbr_m  [NODES*DEG];

    integer seed = 32'h9bcd;
    int     err_cnt = 0;
    int     ack_errs = 0;    // concurrent check failures
    int     drop_errs = 0;
    int     tests_run = 0;
    int     tests_ok = 0;
    int     errs_at_start;
    int     cycles = 0;
    int     both_busy = 0;   // cycles with both PEs holding a node
    string  cur_test;

    always #4 clk = ~clk;   // 8 ns period

    wb_host u_host (
        .clk(clk),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    gnn_top u_gnn_top (
        .clk(clk),
        .rst_n(rst_n),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .task_complete(task_complete)
    );

    // ack only ever answers a strobe from the cycle before
    a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            $display("Wishbone ack arrived without a strobe in the cycle before");
            ack_errs++;
        end

    // task_complete only drops right after an acked access, the restart
    a_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(task_complete) |-> $past(wb_ack))
        else begin
            $display("task_complete fell without a start write just before");
            drop_errs++;
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (u_gnn_top.pe_idle == '0) begin
            both_busy <= both_busy + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [`GNN_WB_ADR_W-1:0] wb_addr(input gnn_ctrl_pkg::wb_region_t region,
                                                          input int ofs);
        return {region, OFS_W'(ofs)};
    endfunction

    function automatic int total_errors();
        return err_cnt + ack_errs + drop_errs + u_host.missed_acks;
    endfunction

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s expected %h actual %h", what, expected, actual);
            err_cnt++;
        end
    endtask

    // one pass of the rule, out = low 16 bits of (sum of neighbor features) * weight
    task automatic model_pass(input gnn_types_pkg::weight_t w);
        gnn_types_pkg::feat_t next [NODES];
        int sum;
        for (int n = 0; n < NODES; n++) begin
            sum = 0;
            for (int k = 0; k < DEG; k++) begin
                sum += feat_m[nbr_m[n*DEG + k]];
            end
            next[n] = 16'((sum * w) & 32'hffff);
        end
        feat_m = next;   // outputs feed the next pass
    endtask

    task automatic load_graph();
        for (int i = 0; i < NODES*DEG; i++) begin
            u_host.write_word(wb_addr(gnn_ctrl_pkg::NBR, i), 16'(nbr_m[i]));
        end
        for (int n = 0; n < NODES; n++) begin
            u_host.write_word(wb_addr(gnn_ctrl_pkg::FEAT, n), feat_m[n]);
        end
    endtask

    task automatic random_features();
        for (int n = 0; n < NODES; n++) begin
            feat_m[n] = gnn_types_pkg::feat_t'($random(seed));
        end
    endtask

    task automatic start_and_wait(input gnn_types_pkg::weight_t w, input int passes);
        int waited;
        waited = 0;
        u_host.write_word(wb_addr(gnn_ctrl_pkg::REG, gnn_ctrl_pkg::WEIGHT), 16'(w));
        u_host.write_word(wb_addr(gnn_ctrl_pkg::REG, gnn_ctrl_pkg::REPLAY), 16'(passes));
        u_host.write_word(wb_addr(gnn_ctrl_pkg::REG, gnn_ctrl_pkg::CTRL), 16'h0001);
        @(posedge clk);
        #1;
        assert (task_complete == 1'b0) else begin
            $display("task_complete still high one cycle after the start write");
            err_cnt++;
        end
        while (!task_complete && waited < RUN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (task_complete) else begin
            $display("task_complete did not rise within %0d cycles", RUN_LIMIT);
            err_cnt++;
        end
    endtask

    task automatic check_outputs();
        gnn_types_pkg::feat_t got;
        for (int n = 0; n < NODES; n++) begin
            u_host.read_word(wb_addr(gnn_ctrl_pkg::OUT, n), got);
            check_value($sformatf("%s out[%0d]", cur_test, n), feat_m[n], got);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = total_errors();
    endtask

    task automatic end_test();
        tests_run++;
        if (total_errors() == errs_at_start) begin
            tests_ok++;
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, total_errors() - errs_at_start);
        end
    endtask

    initial begin
        gnn_types_pkg::feat_t    rd;
        gnn_types_pkg::weight_t  w;
        int                      both_busy_before;
        rst_n = 1'b0;
        u_host.bus_idle();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        begin_test("reset_state");
        check_value({cur_test, " task_complete"}, 16'h0000, {15'b0, task_complete});
        u_host.read_word(wb_addr(gnn_ctrl_pkg::REG, gnn_ctrl_pkg::STATUS), rd);
        check_value({cur_test, " status"}, 16'h0000, rd);
        end_test();

        begin_test("register_readback");
        w = gnn_types_pkg::weight_t'($random(seed));
        u_host.write_word(wb_addr(gnn_ctrl_pkg::REG, gnn_ctrl_pkg::WEIGHT), 16'(w));
        u_host.write_word(wb_addr(gnn_ctrl_pkg::REG, gnn_ctrl_pkg::REPLAY), 16'h0003);
        u_host.read_word(wb_addr(gnn_ctrl_pkg::REG, gnn_ctrl_pkg::WEIGHT), rd);
        check_value({cur_test, " weight"}, 16'(w), rd);
        u_host.read_word(wb_addr(gnn_ctrl_pkg::REG, gnn_ctrl_pkg::REPLAY), rd);
        check_value({cur_test, " replay"}, 16'h0003, rd);
        end_test();

        begin_test("single_pass");
        for (int n = 0; n < NODES; n++) begin
            feat_m[n] = 16'(n * 16'h0111 + 1);   // easy to spot in a wave
            for (int k = 0; k < DEG; k++) begin
                nbr_m[n*DEG + k] = gnn_types_pkg::node_id_t'(n + k + 1);   // ring graph
            end
        end
        load_graph();
        start_and_wait(8'd1, 1);
        model_pass(8'd1);
        check_outputs();
        end_test();

        begin_test("random_contention");
        for (int i = 0; i < NODES*DEG; i++) begin
            nbr_m[i] = gnn_types_pkg::node_id_t'($random(seed));
        end
        random_features();
        load_graph();
        both_busy_before = both_busy;
        start_and_wait(8'd3, 1);
        model_pass(8'd3);
        check_outputs();
        assert (both_busy > both_busy_before) else begin
            $display("the two PEs never held nodes at the same time");
            err_cnt++;
        end
        end_test();

        begin_test("replay_three");
        random_features();
        load_graph();
        start_and_wait(8'd2, 3);
        repeat (3) model_pass(8'd2);
        check_outputs();
        end_test();

        begin_test("restart");
        u_host.read_word(wb_addr(gnn_ctrl_pkg::REG, gnn_ctrl_pkg::STATUS), rd);
        check_value({cur_test, " status before"}, 16'h0001, rd);   // done, not busy
        random_features();   // bank 0 was overwritten by the replay
        load_graph();
        start_and_wait(8'd5, 1);
        model_pass(8'd5);
        check_outputs();
        end_test();

        $display("tests run %0d, ok %0d, errors %0d", tests_run, tests_ok, total_errors());
        if (total_errors() == 0 && tests_ok == NUM_TESTS) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verification/wb_host.sv ====
`include "gnn_params.svh"

module wb_host (
    input  logic                     clk,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`GNN_WB_ADR_W-1:0] wb_adr,
    output gnn_types_pkg::feat_t     wb_dat_w,
    input  gnn_types_pkg::feat_t     wb_dat_r,
    input  logic                     wb_ack
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_LIMIT = 16;   // cycles to wait for an ack

    int missed_acks = 0;   // read by the testbench summary

    task automatic bus_idle();
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
    endtask

    // one classic cycle, entered 1 ns after a rising edge
    task automatic bus_cycle(
        input  logic                     we,
        input  logic [`GNN_WB_ADR_W-1:0] adr,
        input  gnn_types_pkg::feat_t     wdata,
        output gnn_types_pkg::feat_t     rdata
    );
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            #1;   // ack and read data settled by now
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        rdata = wb_dat_r;   // valid in the ack cycle
        if (!wb_ack) begin
            $display("Wishbone slave never acked the access at address %h", adr);
            missed_acks++;
        end
        bus_idle();   // drop strobe before the next edge
    endtask

    task automatic write_word(input logic [`GNN_WB_ADR_W-1:0] adr,
                              input gnn_types_pkg::feat_t data);
        gnn_types_pkg::feat_t ignored;
        bus_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic read_word(input  logic [`GNN_WB_ADR_W-1:0] adr,
                             output gnn_types_pkg::feat_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

endmodule

// ==== src/gnn_top.sv ====
`include "gnn_params.svh"

module gnn_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`GNN_WB_ADR_W-1:0] wb_adr,
    input  gnn_types_pkg::feat_t     wb_dat_w,
    output gnn_types_pkg::feat_t     wb_dat_r,
    output logic                     wb_ack,
    output logic                     task_complete
);

    gnn_types_pkg::pe_mask_t pe_start, pe_idle;
    gnn_types_pkg::pe_mask_t fetch_req, fetch_gnt;
    gnn_types_pkg::pe_mask_t wb_req, wr_gnt;
    gnn_types_pkg::node_id_t pe_node;

    gnn_types_pkg::nbr_idx_t nbr_idx_pe   [`GNN_NUM_PE];
    gnn_types_pkg::node_id_t nbr_id_pe    [`GNN_NUM_PE];
    gnn_types_pkg::node_id_t fetch_nbr_pe [`GNN_NUM_PE];
    gnn_types_pkg::node_id_t wb_node_pe   [`GNN_NUM_PE];
    gnn_types_pkg::feat_t    wb_result_pe [`GNN_NUM_PE];

    gnn_types_pkg::node_id_t fetch_nbr, wr_node, issue_idx;
    gnn_types_pkg::feat_t    fetch_data, wr_data;
    gnn_types_pkg::weight_t  weight;
    gnn_ctrl_pkg::replay_t   replay_cnt;
    logic run_start, bank_sel, busy;
    logic node_issue, pass_advance, issue_last, nodes_all_done, pass_last;

    // one-hot grants pick which PE drives the shared ports
    always_comb begin
        fetch_nbr = '0;
        wr_node   = '0;
        wr_data   = '0;
        for (int p = 0; p < `GNN_NUM_PE; p++) begin
            if (fetch_gnt[p]) begin
                fetch_nbr = fetch_nbr_pe[p];
            end
            if (wr_gnt[p]) begin
                wr_node = wb_node_pe[p];
                wr_data = wb_result_pe[p];
            end
        end
    end

    graph_memory graph_memory_u (
        .clk(clk),
        .rst_n(rst_n),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .fetch_en(|fetch_gnt),
        .fetch_nbr(fetch_nbr),
        .wr_en(|wr_gnt),
        .wr_node(wr_node),
        .wr_data(wr_data),
        .bank_sel(bank_sel),
        .busy(busy),
        .done(task_complete),
        .pe_nbr_idx(nbr_idx_pe),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .fetch_data(fetch_data),
        .nbr_id(nbr_id_pe),
        .run_start(run_start),
        .weight(weight),
        .replay_cnt(replay_cnt)
    );

    task_dispatcher task_dispatcher_u (
        .clk(clk),
        .rst_n(rst_n),
        .run_start(run_start),
        .pe_idle(pe_idle),
        .issue_idx(issue_idx),
        .issue_last(issue_last),
        .nodes_all_done(nodes_all_done),
        .pass_last(pass_last),
        .pe_start(pe_start),
        .pe_node(pe_node),
        .node_issue(node_issue),
        .pass_advance(pass_advance),
        .bank_sel(bank_sel),
        .busy(busy),
        .task_complete(task_complete)
    );

    replay_counter replay_counter_u (
        .clk(clk),
        .rst_n(rst_n),
        .clear(run_start),     // start is only taken when not busy
        .node_issue(node_issue),
        .node_retire(|wr_gnt),  // a granted write-back retires the node
        .pass_advance(pass_advance),
        .replay_cnt(replay_cnt),
        .issue_idx(issue_idx),
        .issue_last(issue_last),
        .nodes_all_done(nodes_all_done),
        .pass_last(pass_last)
    );

    for (genvar p = 0; p < `GNN_NUM_PE; p++) begin : g_pe
        edge_pe edge_pe_u (
            .clk(clk),
            .rst_n(rst_n),
            .start(pe_start[p]),
            .node(pe_node),
            .nbr_id(nbr_id_pe[p]),
            .fetch_gnt(fetch_gnt[p]),
            .fetch_data(fetch_data),   // broadcast, only the granted PE samples it
            .wr_gnt(wr_gnt[p]),
            .weight(weight),
            .idle(pe_idle[p]),
            .nbr_idx(nbr_idx_pe[p]),
            .fetch_req(fetch_req[p]),
            .fetch_nbr(fetch_nbr_pe[p]),
            .wb_req(wb_req[p]),
            .wb_node(wb_node_pe[p]),
            .wb_result(wb_result_pe[p])
        );
    end

    rr_arbiter #(.num_reqs(`GNN_NUM_PE)) fetch_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .reqs(fetch_req),
        .grants(fetch_gnt)
    );

    rr_arbiter #(.num_reqs(`GNN_NUM_PE)) wb_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .reqs(wb_req),
        .grants(wr_gnt)
    );

endmodule

// ==== src/graph_memory.sv ====
`include "gnn_params.svh"

module graph_memory (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`GNN_WB_ADR_W-1:0] wb_adr,
    input  gnn_types_pkg::feat_t     wb_dat_w,
    input  logic                     fetch_en,
    input  gnn_types_pkg::node_id_t  fetch_nbr,
    input  logic                     wr_en,
    input  gnn_types_pkg::node_id_t  wr_node,
    input  gnn_types_pkg::feat_t     wr_data,
    input  logic                     bank_sel,
    input  logic                     busy,
    input  logic                     done,
    input  gnn_types_pkg::nbr_idx_t  pe_nbr_idx [`GNN_NUM_PE],
    output gnn_types_pkg::feat_t     wb_dat_r,
    output logic                     wb_ack,
    output gnn_types_pkg::feat_t     fetch_data,
    output gnn_types_pkg::node_id_t  nbr_id [`GNN_NUM_PE],
    output logic                     run_start,
    output gnn_types_pkg::weight_t   weight,
    output gnn_ctrl_pkg::replay_t    replay_cnt
);

    gnn_types_pkg::feat_t    bank [2][`GNN_NUM_NODES];   // ping-pong feature banks
    gnn_types_pkg::node_id_t nbr_tab [`GNN_NUM_NODES*`GNN_DEGREE];

    gnn_ctrl_pkg::wb_region_t region;
    logic [`GNN_WB_ADR_W-3:0] offs;
    gnn_ctrl_pkg::reg_ofs_t   reg_ofs;
    gnn_types_pkg::node_id_t  node_ofs;
    logic                     host_wr;
    gnn_types_pkg::feat_t     rd_val;

    assign region   = gnn_ctrl_pkg::wb_region_t'(wb_adr[`GNN_WB_ADR_W-1 -: 2]);
    assign offs     = wb_adr[`GNN_WB_ADR_W-3:0];
    assign reg_ofs  = gnn_ctrl_pkg::reg_ofs_t'(offs);
    assign node_ofs = gnn_types_pkg::node_id_t'(offs);
    // writes while a run is going get acked but go nowhere
    assign host_wr  = wb_cyc && wb_stb && !wb_ack && wb_we && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack     <= 1'b0;
            run_start  <= 1'b0;
            weight     <= '0;
            replay_cnt <= '0;
        end else begin
            wb_ack    <= wb_cyc && wb_stb && !wb_ack;   // single cycle ack
            run_start <= host_wr && region == gnn_ctrl_pkg::REG &&
                         reg_ofs == gnn_ctrl_pkg::CTRL && wb_dat_w[0];   // self clearing
            if (host_wr && region == gnn_ctrl_pkg::REG) begin
                if (reg_ofs == gnn_ctrl_pkg::WEIGHT) begin
                    weight <= gnn_types_pkg::weight_t'(wb_dat_w);
                end
                if (reg_ofs == gnn_ctrl_pkg::REPLAY) begin
                    replay_cnt <= gnn_ctrl_pkg::replay_t'(wb_dat_w);
                end
            end
        end
    end

    // host read mux, OUT follows the bank written last
    always_comb begin
        rd_val = '0;
        case (region)
            gnn_ctrl_pkg::REG: begin
                case (reg_ofs)
                    gnn_ctrl_pkg::WEIGHT: rd_val = gnn_types_pkg::feat_t'(weight);
                    gnn_ctrl_pkg::REPLAY: rd_val = gnn_types_pkg::feat_t'(replay_cnt);
                    gnn_ctrl_pkg::STATUS: rd_val = gnn_types_pkg::feat_t'({busy, done});
                    default:              rd_val = '0;   // CTRL reads back zero
                endcase
            end
            gnn_ctrl_pkg::FEAT: rd_val = bank[0][node_ofs];
            gnn_ctrl_pkg::NBR:  rd_val = gnn_types_pkg::feat_t'(nbr_tab[offs]);
            default:            rd_val = bank[bank_sel][node_ofs];
        endcase
    end

    always_ff @(posedge clk) begin
        if (host_wr && region == gnn_ctrl_pkg::FEAT) begin
            bank[0][node_ofs] <= wb_dat_w;   // host loads bank 0 only
        end
        if (wr_en) begin
            bank[~bank_sel][wr_node] <= wr_data;   // results to the other bank
        end
        if (host_wr && region == gnn_ctrl_pkg::NBR) begin
            nbr_tab[offs] <= gnn_types_pkg::node_id_t'(wb_dat_w);
        end
        if (fetch_en) begin
            fetch_data <= bank[bank_sel][fetch_nbr];   // lands the cycle after grant
        end
        for (int p = 0; p < `GNN_NUM_PE; p++) begin
            nbr_id[p] <= nbr_tab[pe_nbr_idx[p]];
        end
        wb_dat_r <= rd_val;   // valid with ack
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack);

endmodule

// ==== src/task_dispatcher.sv ====
module task_dispatcher (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run_start,
    input  gnn_types_pkg::pe_mask_t  pe_idle,
    input  gnn_types_pkg::node_id_t  issue_idx,
    input  logic                     issue_last,
    input  logic                     nodes_all_done,
    input  logic                     pass_last,
    output gnn_types_pkg::pe_mask_t  pe_start,
    output gnn_types_pkg::node_id_t  pe_node,
    output logic                     node_issue,
    output logic                     pass_advance,
    output logic                     bank_sel,
    output logic                     busy,
    output logic                     task_complete
);

    gnn_ctrl_pkg::disp_state_t state, state_nxt;

    assign pe_node = issue_idx;   // same node broadcast to all PEs
    // lowest idle PE wins the node
    assign pe_start = (state == gnn_ctrl_pkg::ISSUE) ?
                      gnn_types_pkg::pe_mask_t'(pe_idle & (~pe_idle + 1'b1)) : '0;
    assign node_issue    = |pe_start;
    assign pass_advance  = (state == gnn_ctrl_pkg::SWAP);
    assign busy          = (state != gnn_ctrl_pkg::IDLE) && (state != gnn_ctrl_pkg::DONE);
    assign task_complete = (state == gnn_ctrl_pkg::DONE);   // drops on restart

    always_comb begin
        state_nxt = state;
        case (state)
            gnn_ctrl_pkg::IDLE,
            gnn_ctrl_pkg::DONE: begin
                if (run_start) begin
                    state_nxt = gnn_ctrl_pkg::ISSUE;
                end
            end
            gnn_ctrl_pkg::ISSUE: begin
                if (node_issue && issue_last) begin
                    state_nxt = gnn_ctrl_pkg::DRAIN;
                end
            end
            gnn_ctrl_pkg::DRAIN: begin
                if (nodes_all_done) begin
                    state_nxt = gnn_ctrl_pkg::SWAP;
                end
            end
            gnn_ctrl_pkg::SWAP: begin
                state_nxt = pass_last ? gnn_ctrl_pkg::DONE : gnn_ctrl_pkg::ISSUE;
            end
            default: state_nxt = gnn_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= gnn_ctrl_pkg::IDLE;
            bank_sel <= 1'b0;
        end else begin
            state <= state_nxt;
            if (run_start && !busy) begin
                bank_sel <= 1'b0;   // host features sit in bank 0
            end else if (pass_advance) begin
                bank_sel <= ~bank_sel;   // also flips after last pass, OUT reads it
            end
        end
    end

    a_start_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pe_start));
    // the chosen PE has to leave idle on the next cycle
    a_start_taken: assert property (@(posedge clk) disable iff (!rst_n)
        |pe_start |=> ($past(pe_start) & pe_idle) == '0);

endmodule

// ==== src/replay_counter.sv ====
`include "gnn_params.svh"

module replay_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic                     node_issue,
    input  logic                     node_retire,
    input  logic                     pass_advance,
    input  gnn_ctrl_pkg::replay_t    replay_cnt,
    output gnn_types_pkg::node_id_t  issue_idx,
    output logic                     issue_last,
    output logic                     nodes_all_done,
    output logic                     pass_last
);

    logic [$clog2(`GNN_NUM_NODES):0] retired;   // counts up to NUM_NODES
    gnn_ctrl_pkg::replay_t           pass_idx;
    gnn_ctrl_pkg::replay_t           pass_total;

    assign pass_total     = (replay_cnt == '0) ? gnn_ctrl_pkg::replay_t'(1) : replay_cnt;
    assign issue_last     = (issue_idx == gnn_types_pkg::node_id_t'(`GNN_NUM_NODES - 1));
    assign nodes_all_done = (retired == `GNN_NUM_NODES);
    assign pass_last      = (pass_idx == pass_total - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_idx <= '0;
            retired   <= '0;
            pass_idx  <= '0;
        end else if (clear || pass_advance) begin
            issue_idx <= '0;   // per-pass counts restart
            retired   <= '0;
            pass_idx  <= clear ? '0 : pass_idx + 1'b1;
        end else begin
            if (node_issue) begin
                issue_idx <= issue_idx + 1'b1;
            end
            if (node_retire) begin
                retired <= retired + 1'b1;   // one write-back grant per cycle at most
            end
        end
    end

endmodule

// ==== src/edge_pe.sv ====
`include "gnn_params.svh"

module edge_pe (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  gnn_types_pkg::node_id_t  node,
    input  gnn_types_pkg::node_id_t  nbr_id,
    input  logic                     fetch_gnt,
    input  gnn_types_pkg::feat_t     fetch_data,
    input  logic                     wr_gnt,
    input  gnn_types_pkg::weight_t   weight,
    output logic                     idle,
    output gnn_types_pkg::nbr_idx_t  nbr_idx,
    output logic                     fetch_req,
    output gnn_types_pkg::node_id_t  fetch_nbr,
    output logic                     wb_req,
    output gnn_types_pkg::node_id_t  wb_node,
    output gnn_types_pkg::feat_t     wb_result
);

    typedef enum logic [2:0] {
        PE_IDLE,
        PE_LOOK,    // first neighbor id in flight
        PE_REQ,     // fetch request held until granted
        PE_DATA,    // feature arrives, next id looked up
        PE_SCALE,
        PE_WB       // write-back request held until granted
    } pe_state_t;

    pe_state_t                       state;
    logic [$clog2(`GNN_DEGREE)-1:0]  k;
    logic [$clog2(`GNN_DEGREE)-1:0]  k_sel;
    gnn_types_pkg::node_id_t         cur_node;
    gnn_types_pkg::acc_t             acc;

    assign idle      = (state == PE_IDLE);
    assign fetch_req = (state == PE_REQ);
    assign fetch_nbr = nbr_id;   // stable while requesting
    assign wb_req    = (state == PE_WB);
    assign wb_node   = cur_node;

    // look one neighbor ahead during DATA, wraps harmlessly on the last
    assign k_sel   = (state == PE_DATA) ? k + 1'b1 : k;
    assign nbr_idx = gnn_types_pkg::nbr_idx_t'(cur_node * `GNN_DEGREE + k_sel);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PE_IDLE;
            k     <= '0;
        end else begin
            case (state)
                PE_IDLE: begin
                    if (start) begin
                        state <= PE_LOOK;
                        k     <= '0;
                    end
                end
                PE_LOOK: state <= PE_REQ;
                PE_REQ: begin
                    if (fetch_gnt) begin
                        state <= PE_DATA;
                    end
                end
                PE_DATA: begin
                    if (k == `GNN_DEGREE - 1) begin
                        state <= PE_SCALE;
                    end else begin
                        state <= PE_REQ;
                        k     <= k + 1'b1;
                    end
                end
                PE_SCALE: state <= PE_WB;
                PE_WB: begin
                    if (wr_gnt) begin
                        state <= PE_IDLE;   // retires, memory written this cycle
                    end
                end
                default: state <= PE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && start) begin
            cur_node <= node;
            acc      <= '0;
        end
        if (state == PE_DATA) begin
            acc <= acc + gnn_types_pkg::acc_t'(fetch_data);
        end
        if (state == PE_SCALE) begin
            wb_result <= gnn_types_pkg::feat_t'(acc * weight);   // keep low bits
        end
    end

endmodule

// ==== src/rr_arbiter.sv ====
module rr_arbiter #(
    parameter int num_reqs = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [num_reqs-1:0] reqs,
    output logic [num_reqs-1:0] grants
);

    logic [num_reqs-1:0] mask_q;   // requesters above the last winner
    logic [num_reqs-1:0] masked;

    assign masked = reqs & mask_q;

    always_comb begin
        if (|masked) begin
            grants = masked & (~masked + 1'b1);   // lowest above last grant
        end else begin
            grants = reqs & (~reqs + 1'b1);   // wrap around
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= '1;
        end else if (|grants) begin
            mask_q <= ~((grants << 1) - 1'b1);   // rotate past winner
        end
    end

    a_gnt_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        (grants & ~reqs) == '0);

endmodule

// ==== src/gnn_ctrl_pkg.sv ====
`include "gnn_params.svh"

package gnn_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,    // after reset, waits for start
        ISSUE,   // hands nodes to idle PEs
        DRAIN,   // all issued, waiting on write-backs
        SWAP,    // flip banks, next pass
        DONE     // task_complete held here
    } disp_state_t;

    typedef enum logic [1:0] {REG, FEAT, NBR, OUT} wb_region_t;   // wb_adr top bits

    typedef logic [$clog2(`GNN_MAX_REPLAY):0] replay_t;   // pass count, 0 runs once

    typedef logic [1:0] reg_ofs_t;
    localparam reg_ofs_t CTRL   = 2'd0;   // bit 0 starts a run
    localparam reg_ofs_t WEIGHT = 2'd1;
    localparam reg_ofs_t REPLAY = 2'd2;
    localparam reg_ofs_t STATUS = 2'd3;   // {busy, done}, read only

endpackage

// ==== src/gnn_types_pkg.sv ====
`include "gnn_params.svh"

package gnn_types_pkg;

    typedef logic [$clog2(`GNN_NUM_NODES)-1:0] node_id_t;   // node index
    typedef logic [`GNN_FEAT_W-1:0]             feat_t;      // also the wishbone data width
    typedef logic [`GNN_FEAT_W+1:0]             acc_t;       // room for DEGREE summed features
    typedef logic [7:0]                         weight_t;
    typedef logic [`GNN_NUM_PE-1:0]             pe_mask_t;   // one bit per PE

    // flat neighbor table index, node * DEGREE + k
    typedef logic [$clog2(`GNN_NUM_NODES*`GNN_DEGREE)-1:0] nbr_idx_t;

endpackage

// ==== src/gnn_params.svh ====
`ifndef GNN_PARAMS_SVH
`define GNN_PARAMS_SVH

`define GNN_NUM_PE      2    // edge PEs in the pool
`define GNN_NUM_NODES   16
`define GNN_DEGREE      4    // fixed neighbors per node
`define GNN_FEAT_W      16
`define GNN_MAX_REPLAY  4    // most passes per run
`define GNN_WB_ADR_W    8    // top two bits pick the region

`endif
